/* source/dvi_pkg.sv */
// --------------------------------------------------
// Shared types and constants of the DVI video path
// Position fields are 11 bits and limit a total to 2048
// TMDS control codes are written bit 9 first
// --------------------------------------------------
`default_nettype none

package dvi_pkg;

	typedef logic [10:0] t_pos;

	// One raster position with its timing flags
	typedef struct packed {
		t_pos x;
		t_pos y;
		logic hsync;
		logic vsync;
		logic de;          // Active region
		logic frame_start; // Pixel 0,0
	} t_raster;

	// Pixel as consumed by the encoders
	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
		logic       hsync;
		logic       vsync;
		logic       de;
	} t_pixel;

	typedef struct packed {
		logic [9:0] ch2;
		logic [9:0] ch1;
		logic [9:0] ch0;
	} t_tmds;

	// Control codes indexed by {c1, c0}
	localparam logic [9:0] TMDS_CTRL_00 = 10'b1101010100;
	localparam logic [9:0] TMDS_CTRL_01 = 10'b0010101011;
	localparam logic [9:0] TMDS_CTRL_10 = 10'b0101010100;
	localparam logic [9:0] TMDS_CTRL_11 = 10'b1010101011;

	// --------------------------------------------------
	// 640x480p 60 Hz

	localparam int DEFAULT_H_FRONT_PORCH   = 16;
	localparam int DEFAULT_H_SYNC_WIDTH    = 96;
	localparam int DEFAULT_H_BACK_PORCH    = 48;
	localparam int DEFAULT_H_ACTIVE_PIXELS = 640;
	localparam bit DEFAULT_H_SYNC_POLARITY = 1'b0; // Active low

	localparam int DEFAULT_V_FRONT_PORCH   = 10;
	localparam int DEFAULT_V_SYNC_WIDTH    = 2;
	localparam int DEFAULT_V_BACK_PORCH    = 33;
	localparam int DEFAULT_V_ACTIVE_LINES  = 480;
	localparam bit DEFAULT_V_SYNC_POLARITY = 1'b0; // Active low

endpackage

`default_nettype wire

/* source/dvi_tx_core.sv */
// --------------------------------------------------
// DVI transmit core in the pixel clock domain
// Outputs parallel 10-bit symbols, no serialiser
// Two cycles from timing register to symbol
// --------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module dvi_tx_core import dvi_pkg::*; #(
	parameter int H_FRONT_PORCH   = DEFAULT_H_FRONT_PORCH,
	parameter int H_SYNC_WIDTH    = DEFAULT_H_SYNC_WIDTH,
	parameter int H_BACK_PORCH    = DEFAULT_H_BACK_PORCH,
	parameter int H_ACTIVE_PIXELS = DEFAULT_H_ACTIVE_PIXELS,
	parameter bit H_SYNC_POLARITY = DEFAULT_H_SYNC_POLARITY,
	parameter int V_FRONT_PORCH   = DEFAULT_V_FRONT_PORCH,
	parameter int V_SYNC_WIDTH    = DEFAULT_V_SYNC_WIDTH,
	parameter int V_BACK_PORCH    = DEFAULT_V_BACK_PORCH,
	parameter int V_ACTIVE_LINES  = DEFAULT_V_ACTIVE_LINES,
	parameter bit V_SYNC_POLARITY = DEFAULT_V_SYNC_POLARITY
) (
	input  logic  clk_dvi_pix,
	input  logic  rst_n_dvi_pix,
	output t_tmds o_tmds
);

	t_raster    raster;
	t_pixel     pixel;
	logic [9:0] sym0;
	logic [9:0] sym1;
	logic [9:0] sym2;

	video_timing_gen #(
		.H_FRONT_PORCH   (H_FRONT_PORCH),
		.H_SYNC_WIDTH    (H_SYNC_WIDTH),
		.H_BACK_PORCH    (H_BACK_PORCH),
		.H_ACTIVE_PIXELS (H_ACTIVE_PIXELS),
		.H_SYNC_POLARITY (H_SYNC_POLARITY),
		.V_FRONT_PORCH   (V_FRONT_PORCH),
		.V_SYNC_WIDTH    (V_SYNC_WIDTH),
		.V_BACK_PORCH    (V_BACK_PORCH),
		.V_ACTIVE_LINES  (V_ACTIVE_LINES),
		.V_SYNC_POLARITY (V_SYNC_POLARITY)
	) timing_i (
		.clk_dvi_pix   (clk_dvi_pix),
		.rst_n_dvi_pix (rst_n_dvi_pix),
		.o_raster      (raster)
	);

	test_pattern_gen #(
		.H_SYNC_POLARITY (H_SYNC_POLARITY),
		.V_SYNC_POLARITY (V_SYNC_POLARITY)
	) pattern_i (
		.clk_dvi_pix   (clk_dvi_pix),
		.rst_n_dvi_pix (rst_n_dvi_pix),
		.i_raster      (raster),
		.o_pixel       (pixel)
	);

	// --------------------------------------------------
	// Channel 0 carries the syncs as c1 = vsync, c0 = hsync

	tmds_encoder #(
		.RST_CTRL ({~V_SYNC_POLARITY, ~H_SYNC_POLARITY})
	) enc0_i (
		.clk_dvi_pix   (clk_dvi_pix),
		.rst_n_dvi_pix (rst_n_dvi_pix),
		.i_data        (pixel.b),
		.i_ctrl        ({pixel.vsync, pixel.hsync}),
		.i_de          (pixel.de),
		.o_symbol      (sym0)
	);

	tmds_encoder #(
		.RST_CTRL (2'b00)
	) enc1_i (
		.clk_dvi_pix   (clk_dvi_pix),
		.rst_n_dvi_pix (rst_n_dvi_pix),
		.i_data        (pixel.g),
		.i_ctrl        (2'b00),
		.i_de          (pixel.de),
		.o_symbol      (sym1)
	);

	tmds_encoder #(
		.RST_CTRL (2'b00)
	) enc2_i (
		.clk_dvi_pix   (clk_dvi_pix),
		.rst_n_dvi_pix (rst_n_dvi_pix),
		.i_data        (pixel.r),
		.i_ctrl        (2'b00),
		.i_de          (pixel.de),
		.o_symbol      (sym2)
	);

	assign o_tmds = '{ch2: sym2, ch1: sym1, ch0: sym0};

endmodule

`default_nettype wire

/* source/test_pattern_gen.sv */
// --------------------------------------------------
// Moving colour test pattern, one register stage
// Frame count starts at 0 with the first frame
// Colours are zero outside the active region
// --------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module test_pattern_gen import dvi_pkg::*; #(
	parameter bit H_SYNC_POLARITY = 1'b0,
	parameter bit V_SYNC_POLARITY = 1'b0
) (
	input  logic    clk_dvi_pix,
	input  logic    rst_n_dvi_pix,
	input  t_raster i_raster,
	output t_pixel  o_pixel
);

	logic [10:0] frame_cnt;
	logic [10:0] frame_cur;
	logic        seen_first;
	logic [10:0] r_sum;
	logic [10:0] g_sum;

	// Count applies from pixel 0,0 of the new frame
	assign frame_cur = (i_raster.frame_start && seen_first) ? frame_cnt + 1'b1 : frame_cnt;

	assign r_sum = i_raster.x + frame_cur;
	assign g_sum = i_raster.y + frame_cur;

	always_ff @(posedge clk_dvi_pix or negedge rst_n_dvi_pix) begin
		if (!rst_n_dvi_pix) begin
			frame_cnt  <= '0;
			seen_first <= 1'b0;
		end else begin
			frame_cnt <= frame_cur;
			if (i_raster.frame_start)
				seen_first <= 1'b1;
		end
	end

	// --------------------------------------------------
	// Pixel register, sync and de delayed alongside

	always_ff @(posedge clk_dvi_pix or negedge rst_n_dvi_pix) begin
		if (!rst_n_dvi_pix) begin
			o_pixel.r     <= '0;
			o_pixel.g     <= '0;
			o_pixel.b     <= '0;
			o_pixel.hsync <= ~H_SYNC_POLARITY;
			o_pixel.vsync <= ~V_SYNC_POLARITY;
			o_pixel.de    <= 1'b0;
		end else begin
			o_pixel.r     <= i_raster.de ? {r_sum[5:0], 2'b00} : 8'h00;
			o_pixel.g     <= i_raster.de ? {g_sum[5:0], 2'b00} : 8'h00;
			o_pixel.b     <= i_raster.de ? frame_cur[7:0] : 8'h00;
			o_pixel.hsync <= i_raster.hsync;
			o_pixel.vsync <= i_raster.vsync;
			o_pixel.de    <= i_raster.de;
		end
	end

endmodule

`default_nettype wire

/* source/tmds_encoder.sv */
// --------------------------------------------------
// TMDS 8b/10b encoder for one DVI channel
// One cycle from input to symbol
// Disparity is cleared during blanking
// RST_CTRL picks the control code held in reset
// --------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tmds_encoder import dvi_pkg::*; #(
	parameter logic [1:0] RST_CTRL = 2'b00
) (
	input  logic       clk_dvi_pix,
	input  logic       rst_n_dvi_pix,
	input  logic [7:0] i_data,
	input  logic [1:0] i_ctrl,
	input  logic       i_de,
	output logic [9:0] o_symbol
);

	function automatic logic [3:0] popcount8(input logic [7:0] v);
		logic [3:0] n;
		n = '0;
		for (int i = 0; i < 8; i++)
			n = n + {3'b000, v[i]};
		return n;
	endfunction

	function automatic logic [9:0] ctrl_code(input logic [1:0] c);
		case (c)
			2'b00:   return TMDS_CTRL_00;
			2'b01:   return TMDS_CTRL_01;
			2'b10:   return TMDS_CTRL_10;
			default: return TMDS_CTRL_11;
		endcase
	endfunction

	logic [3:0]        n1_data;
	logic              use_xnor;
	logic [8:0]        q_m;
	logic [3:0]        n1_qm;
	logic signed [5:0] diff_qm; // Ones minus zeros of q_m[7:0]
	logic signed [5:0] cnt;
	logic signed [5:0] cnt_next;
	logic [9:0]        sym_next;

	// --------------------------------------------------
	// Transition minimisation

	assign n1_data  = popcount8(i_data);
	assign use_xnor = (n1_data > 4'd4) || ((n1_data == 4'd4) && !i_data[0]);

	always_comb begin
		q_m[0] = i_data[0];
		for (int i = 1; i < 8; i++)
			q_m[i] = use_xnor ? ~(q_m[i-1] ^ i_data[i]) : (q_m[i-1] ^ i_data[i]);
		q_m[8] = ~use_xnor;
	end

	assign n1_qm   = popcount8(q_m[7:0]);
	assign diff_qm = $signed({1'b0, n1_qm, 1'b0}) - 6'sd8;

	// --------------------------------------------------
	// DC balance

	always_comb begin
		if (cnt == 6'sd0 || n1_qm == 4'd4) begin
			sym_next = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
			cnt_next = q_m[8] ? cnt + diff_qm : cnt - diff_qm;
		end else if ((!cnt[5] && n1_qm > 4'd4) || (cnt[5] && n1_qm < 4'd4)) begin
			sym_next = {1'b1, q_m[8], ~q_m[7:0]}; // Invert to pull back
			cnt_next = cnt + (q_m[8] ? 6'sd2 : 6'sd0) - diff_qm;
		end else begin
			sym_next = {1'b0, q_m[8], q_m[7:0]};
			cnt_next = cnt - (q_m[8] ? 6'sd0 : 6'sd2) + diff_qm;
		end
	end

	always_ff @(posedge clk_dvi_pix or negedge rst_n_dvi_pix) begin
		if (!rst_n_dvi_pix) begin
			o_symbol <= ctrl_code(RST_CTRL);
			cnt      <= '0;
		end else if (i_de) begin
			o_symbol <= sym_next;
			cnt      <= cnt_next;
		end else begin
			o_symbol <= ctrl_code(i_ctrl); // Blanking
			cnt      <= '0;
		end
	end

endmodule

`default_nettype wire

/* source/video_timing_gen.sv */
// --------------------------------------------------
// Raster timing generator, free running, no enable
// Line order: active, front porch, sync, back porch
// Output is registered one cycle behind the counters
// Total counts must fit in 11 bits
// --------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module video_timing_gen import dvi_pkg::*; #(
	parameter int H_FRONT_PORCH   = 16,
	parameter int H_SYNC_WIDTH    = 96,
	parameter int H_BACK_PORCH    = 48,
	parameter int H_ACTIVE_PIXELS = 640,
	parameter bit H_SYNC_POLARITY = 1'b0,
	parameter int V_FRONT_PORCH   = 10,
	parameter int V_SYNC_WIDTH    = 2,
	parameter int V_BACK_PORCH    = 33,
	parameter int V_ACTIVE_LINES  = 480,
	parameter bit V_SYNC_POLARITY = 1'b0
) (
	input  logic    clk_dvi_pix,
	input  logic    rst_n_dvi_pix,
	output t_raster o_raster
);

	localparam int H_SYNC_START = H_ACTIVE_PIXELS + H_FRONT_PORCH;
	localparam int H_SYNC_END   = H_SYNC_START + H_SYNC_WIDTH;
	localparam int H_TOTAL      = H_SYNC_END + H_BACK_PORCH;
	localparam int V_SYNC_START = V_ACTIVE_LINES + V_FRONT_PORCH;
	localparam int V_SYNC_END   = V_SYNC_START + V_SYNC_WIDTH;
	localparam int V_TOTAL      = V_SYNC_END + V_BACK_PORCH;

	t_pos h_cnt;
	t_pos v_cnt;
	logic h_last;
	logic v_last;
	logic h_in_sync;
	logic v_in_sync;

	assign h_last = (h_cnt == t_pos'(H_TOTAL - 1));
	assign v_last = (v_cnt == t_pos'(V_TOTAL - 1));

	assign h_in_sync = (h_cnt >= t_pos'(H_SYNC_START)) && (h_cnt < t_pos'(H_SYNC_END));
	assign v_in_sync = (v_cnt >= t_pos'(V_SYNC_START)) && (v_cnt < t_pos'(V_SYNC_END));

	// --------------------------------------------------
	// Position counters over the whole frame

	always_ff @(posedge clk_dvi_pix or negedge rst_n_dvi_pix) begin
		if (!rst_n_dvi_pix) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else begin
			if (h_last) begin
				h_cnt <= '0;
				v_cnt <= v_last ? '0 : v_cnt + 1'b1; // Next line at end of line
			end else begin
				h_cnt <= h_cnt + 1'b1;
			end
		end
	end

	// --------------------------------------------------
	// Timing register

	always_ff @(posedge clk_dvi_pix or negedge rst_n_dvi_pix) begin
		if (!rst_n_dvi_pix) begin
			o_raster.x           <= '0;
			o_raster.y           <= '0;
			o_raster.hsync       <= ~H_SYNC_POLARITY; // Idle level
			o_raster.vsync       <= ~V_SYNC_POLARITY;
			o_raster.de          <= 1'b0;
			o_raster.frame_start <= 1'b0;
		end else begin
			o_raster.x           <= h_cnt;
			o_raster.y           <= v_cnt;
			o_raster.hsync       <= h_in_sync ? H_SYNC_POLARITY : ~H_SYNC_POLARITY;
			o_raster.vsync       <= v_in_sync ? V_SYNC_POLARITY : ~V_SYNC_POLARITY;
			o_raster.de          <= (h_cnt < t_pos'(H_ACTIVE_PIXELS)) &&
				(v_cnt < t_pos'(V_ACTIVE_LINES));
			o_raster.frame_start <= (h_cnt == '0) && (v_cnt == '0);
		end
	end

endmodule

`default_nettype wire

/* sources.f */
+incdir+verif
source/dvi_pkg.sv
source/video_timing_gen.sv
source/test_pattern_gen.sv
source/tmds_encoder.sv
source/dvi_tx_core.sv
verif/dvi_tx_tb.sv

/* verif/tmds_tb_util.svh */
// --------------------------------------------------
// TMDS symbol helpers for the testbench
// Symbols are 10-bit words as the encoder outputs them
// Needs dvi_pkg imported by the including module
// --------------------------------------------------
`ifndef TMDS_TB_UTIL_SVH
`define TMDS_TB_UTIL_SVH

function automatic int ones_of(input logic [9:0] s);
	int n;
	n = 0;
	for (int i = 0; i < 10; i++)
		n += s[i];
	return n;
endfunction

// Ones minus zeros of one symbol
function automatic int balance_of(input logic [9:0] s);
	return 2 * ones_of(s) - 10;
endfunction

function automatic bit is_ctrl(input logic [9:0] s);
	return (s == TMDS_CTRL_00) || (s == TMDS_CTRL_01) ||
		(s == TMDS_CTRL_10) || (s == TMDS_CTRL_11);
endfunction

function automatic logic [1:0] ctrl_bits(input logic [9:0] s);
	if (s == TMDS_CTRL_01)
		return 2'b01;
	if (s == TMDS_CTRL_10)
		return 2'b10;
	if (s == TMDS_CTRL_11)
		return 2'b11;
	return 2'b00;
endfunction

function automatic logic [7:0] decode_byte(input logic [9:0] s);
	logic [7:0] d;
	logic [7:0] b;
	d = s[9] ? ~s[7:0] : s[7:0]; // Undo DC inversion
	b[0] = d[0];
	for (int i = 1; i < 8; i++)
		b[i] = s[8] ? (d[i] ^ d[i-1]) : ~(d[i] ^ d[i-1]);
	return b;
endfunction

function automatic bit data_code_valid(input logic [9:0] s);
	logic [7:0] b;
	int         n;
	b = decode_byte(s);
	n = 0;
	for (int i = 0; i < 8; i++)
		n += b[i];
	// Bit 8 has to name the XOR chain exactly when the byte calls for it
	return !is_ctrl(s) && (s[8] == ((n < 4) || ((n == 4) && b[0])));
endfunction

`endif

/* verif/dvi_tx_tb.sv */
// --------------------------------------------------
// Testbench for the DVI core on an 8x4 raster
// Model state is set at the falling edge
// Checks sample it at the next rising edge
// Runs 5 frames and stops at the first failure
// --------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module dvi_tx_tb import dvi_pkg::*; ();

	localparam int H_ACT      = 8;
	localparam int H_FP       = 2;
	localparam int H_SW       = 3;
	localparam int H_BP       = 2;
	localparam int V_ACT      = 4;
	localparam int V_FP       = 1;
	localparam int V_SW       = 1;
	localparam int V_BP       = 1;
	localparam int H_TOT      = H_ACT + H_FP + H_SW + H_BP;
	localparam int V_TOT      = V_ACT + V_FP + V_SW + V_BP;
	localparam int LATENCY    = 3; // Timing register plus two pipeline stages
	localparam int NUM_FRAMES = 5;
	localparam int MAX_CYCLES = 2 * NUM_FRAMES * H_TOT * V_TOT;
	localparam int DISP_LIMIT = 20;

	logic       clk_dvi_pix;
	logic       rst_n_dvi_pix;
	t_tmds      tmds;
	int         edge_cnt; // Rising edges since reset release
	int         mx;
	int         my;
	int         mf;
	logic       exp_de;
	logic       exp_hs;
	logic       exp_vs;
	logic [9:0] got_sym [3];
	logic [7:0] exp_byte [3];
	logic [9:0] got_val [3];
	logic [9:0] exp_val [3];
	string      kind [3];
	bit         val_ok [3];
	bit         code_ok [3];
	int         disp [3];
	int         run_len;
	int         run_seen;
	bit         run_end;
	int         data_lines;
	int         lines_seen;
	bit         frame_end;
	int         data_total;
	bit         run_done;

	`include "tmds_tb_util.svh"

	dvi_tx_core #(
		.H_FRONT_PORCH   (H_FP),
		.H_SYNC_WIDTH    (H_SW),
		.H_BACK_PORCH    (H_BP),
		.H_ACTIVE_PIXELS (H_ACT),
		.H_SYNC_POLARITY (1'b0),
		.V_FRONT_PORCH   (V_FP),
		.V_SYNC_WIDTH    (V_SW),
		.V_BACK_PORCH    (V_BP),
		.V_ACTIVE_LINES  (V_ACT),
		.V_SYNC_POLARITY (1'b0)
	) dut_i (
		.clk_dvi_pix   (clk_dvi_pix),
		.rst_n_dvi_pix (rst_n_dvi_pix),
		.o_tmds        (tmds)
	);

	always #50 clk_dvi_pix = ~clk_dvi_pix;

	task automatic stop_on_failure();
		$display("Simulation failed");
		$fatal(1, "stopped at the first failing check");
	endtask

	always @(posedge clk_dvi_pix or negedge rst_n_dvi_pix) begin
		if (!rst_n_dvi_pix)
			edge_cnt <= 0;
		else
			edge_cnt <= edge_cnt + 1;
	end

	// --------------------------------------------------
	// Raster model with one output symbol per falling edge

	always @(negedge clk_dvi_pix) begin
		got_sym[0] = tmds.ch0;
		got_sym[1] = tmds.ch1;
		got_sym[2] = tmds.ch2;
		mf = 0;
		if (edge_cnt < LATENCY) begin
			mx = 0;
			my = 0;
			exp_de = 1'b0; // Still the reset symbols
			exp_hs = 1'b1;
			exp_vs = 1'b1;
		end else begin
			mx = (edge_cnt - LATENCY) % H_TOT;
			my = ((edge_cnt - LATENCY) / H_TOT) % V_TOT;
			mf = (edge_cnt - LATENCY) / (H_TOT * V_TOT);
			exp_de = (mx < H_ACT) && (my < V_ACT);
			exp_hs = !((mx >= H_ACT + H_FP) && (mx < H_ACT + H_FP + H_SW));
			exp_vs = !((my >= V_ACT + V_FP) && (my < V_ACT + V_FP + V_SW));
		end
		exp_byte[0] = 8'(mf);
		exp_byte[1] = 8'((my + mf) * 4);
		exp_byte[2] = 8'((mx + mf) * 4);
		for (int c = 0; c < 3; c++) begin
			if (exp_de) begin
				kind[c]    = "data byte";
				got_val[c] = {2'b00, decode_byte(got_sym[c])};
				exp_val[c] = {2'b00, exp_byte[c]};
				code_ok[c] = data_code_valid(got_sym[c]);
			end else if (c == 0) begin
				kind[c]    = "control bits";
				got_val[c] = {8'h00, ctrl_bits(got_sym[c])};
				exp_val[c] = {8'h00, exp_vs, exp_hs};
				code_ok[c] = is_ctrl(got_sym[c]);
			end else begin
				kind[c]    = "symbol";
				got_val[c] = got_sym[c];
				exp_val[c] = TMDS_CTRL_00;
				code_ok[c] = 1'b1;
			end
			val_ok[c] = (got_val[c] == exp_val[c]);
			disp[c] = is_ctrl(got_sym[c]) ? 0 : disp[c] + balance_of(got_sym[c]);
		end
		run_end   = 1'b0;
		frame_end = 1'b0;
		if (!is_ctrl(got_sym[0])) begin
			run_len++;
			if (mf < NUM_FRAMES)
				data_total++;
		end else if (run_len != 0) begin
			run_end  = 1'b1; // Line of data just closed
			run_seen = run_len;
			run_len  = 0;
			data_lines++;
		end
		if ((edge_cnt >= LATENCY) && (mx == 0) && (my == 0) && (mf > 0)) begin
			frame_end  = 1'b1;
			lines_seen = data_lines;
			data_lines = 0;
		end
		// One cycle after the line count of the last frame is checked
		run_done = (edge_cnt >= LATENCY) && (mf >= NUM_FRAMES) && (mx > 0);
	end

	// --------------------------------------------------
	// Checks

	for (genvar c = 0; c < 3; c++) begin : chan_chk
		assert property (@(posedge clk_dvi_pix) disable iff (!rst_n_dvi_pix) val_ok[c])
		else begin
			$display("Error: ch%0d %s got 0x%h expected 0x%h", c, kind[c], got_val[c],
				exp_val[c]);
			stop_on_failure();
		end
		assert property (@(posedge clk_dvi_pix) disable iff (!rst_n_dvi_pix) code_ok[c])
		else begin
			$display("ch%0d sent symbol 0x%h, which is no valid %s code", c, got_sym[c],
				exp_de ? "data" : "control");
			stop_on_failure();
		end
		assert property (@(posedge clk_dvi_pix) disable iff (!rst_n_dvi_pix)
			(disp[c] <= DISP_LIMIT) && (disp[c] >= -DISP_LIMIT))
		else begin
			$display("ch%0d running disparity %0d is out of range", c, disp[c]);
			stop_on_failure();
		end
	end

	assert property (@(posedge clk_dvi_pix) disable iff (!rst_n_dvi_pix)
		!run_end || (run_seen == H_ACT))
	else begin
		$display("Error: data run length got 0x%h expected 0x%h", run_seen, H_ACT);
		stop_on_failure();
	end

	assert property (@(posedge clk_dvi_pix) disable iff (!rst_n_dvi_pix)
		!frame_end || (lines_seen == V_ACT))
	else begin
		$display("Error: data lines per frame got 0x%h expected 0x%h", lines_seen, V_ACT);
		stop_on_failure();
	end

	initial begin
		int cycles;
		clk_dvi_pix   = 1'b0;
		rst_n_dvi_pix = 1'b0;
		cycles        = 0;
		repeat (3) @(negedge clk_dvi_pix);
		rst_n_dvi_pix = 1'b1;
		while (!run_done) begin
			@(posedge clk_dvi_pix);
			cycles++;
			if (cycles > MAX_CYCLES) begin
				$display("Timed out after %0d cycles waiting for %0d frames", cycles,
					NUM_FRAMES);
				stop_on_failure();
			end
		end
		if (data_total != NUM_FRAMES * H_ACT * V_ACT) begin
			$display("Error: data_total got 0x%h expected 0x%h", data_total,
				NUM_FRAMES * H_ACT * V_ACT);
			stop_on_failure();
		end else begin
			$display("Simulation passed");
			$finish;
		end
	end

endmodule

`default_nettype wire
